//--- logic/flight_pkg.sv
/*
 * shared types, register map and reset defaults for the attitude path
 * limit defaults are given in 1/16 units and assume frac_bits = 4
 * gains are unsigned and tilt limits are kept non-negative by ctrl_regs
 */
package flight_pkg;

	// receiver stick, 0 to 250
	typedef logic [7:0] rx_t;
	// 12.4 signed fixed point for angles, rates and motor commands
	typedef logic signed [15:0] rate_t;
	// gain in 1/16 steps
	typedef logic [7:0] gain_t;
	typedef logic [15:0] wb_data_t;

	// one-hot angle controller states
	typedef enum logic [4:0] {
		ang_wait  = 5'b00001,
		ang_map   = 5'b00010,
		ang_scale = 5'b00100,
		ang_limit = 5'b01000,
		ang_done  = 5'b10000
	} ang_state_t;

	// word addresses
	localparam logic [2:0] reg_yaw_gain = 3'd0;
	localparam logic [2:0] reg_tilt_gain = 3'd1;
	localparam logic [2:0] reg_rate_gain = 3'd2;
	localparam logic [2:0] reg_tilt_limit = 3'd3;
	localparam logic [2:0] reg_thr_limit = 3'd4;
	localparam logic [2:0] reg_status = 3'd5;

	localparam gain_t def_yaw_gain = 8'd48;
	localparam gain_t def_tilt_gain = 8'd32;
	localparam gain_t def_rate_gain = 8'd16;
	// 100.0 and 250.0
	localparam rate_t def_tilt_limit = 16'sd1600;
	localparam rate_t def_thr_limit = 16'sd4000;

	// clamp a wide signed value into [lo, hi]
	function automatic rate_t clamp_rate(input logic signed [31:0] val, input rate_t lo,
		input rate_t hi);
		rate_t res;
		if (val > hi)
			res = hi;
		else if (val < lo)
			res = lo;
		else
			res = rate_t'(val);
		return res;
	endfunction

endpackage

//--- logic/ctrl_regs.sv
/*
 * Wishbone classic slave for gains and limits, one wait state per access
 * wb_addr_w must be at least 3; unmapped words read zero and drop writes
 * gain writes keep the low byte; tilt limit writes store the magnitude
 * software should only write while busy reads low
 */
module ctrl_regs #(
	parameter int wb_addr_w = 3
) (
	input logic us_clk,
	input logic resetn,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [wb_addr_w-1:0] wb_adr,
	input flight_pkg::wb_data_t wb_dat_w,
	output flight_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,
	input logic busy,
	output flight_pkg::gain_t yaw_gain,
	output flight_pkg::gain_t tilt_gain,
	output flight_pkg::gain_t rate_gain,
	output flight_pkg::rate_t tilt_limit,
	output flight_pkg::rate_t thr_limit
);
	import flight_pkg::*;

	logic req;
	wb_data_t rd_word;
	rate_t abs_limit;

	// new access, ack not yet given
	assign req = wb_cyc & wb_stb & ~wb_ack;

	// magnitude of written limit, most negative value saturates
	always_comb begin
		if (!wb_dat_w[15])
			abs_limit = $signed(wb_dat_w);
		else if (wb_dat_w == 16'h8000)
			abs_limit = 16'sh7fff;
		else
			abs_limit = -$signed(wb_dat_w);
	end

	// read mux
	always_comb begin
		case (wb_adr)
			wb_addr_w'(reg_yaw_gain): rd_word = {8'd0, yaw_gain};
			wb_addr_w'(reg_tilt_gain): rd_word = {8'd0, tilt_gain};
			wb_addr_w'(reg_rate_gain): rd_word = {8'd0, rate_gain};
			wb_addr_w'(reg_tilt_limit): rd_word = wb_data_t'(tilt_limit);
			wb_addr_w'(reg_thr_limit): rd_word = wb_data_t'(thr_limit);
			wb_addr_w'(reg_status): rd_word = {15'd0, busy};
			default: rd_word = '0;
		endcase
	end

	// single-cycle ack one clock after request
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			wb_ack <= 1'b0;
		else
			wb_ack <= req;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			yaw_gain <= def_yaw_gain;
			tilt_gain <= def_tilt_gain;
			rate_gain <= def_rate_gain;
			tilt_limit <= def_tilt_limit;
			thr_limit <= def_thr_limit;
		end else if (req && wb_we) begin
			case (wb_adr)
				wb_addr_w'(reg_yaw_gain): yaw_gain <= wb_dat_w[7:0];
				wb_addr_w'(reg_tilt_gain): tilt_gain <= wb_dat_w[7:0];
				wb_addr_w'(reg_rate_gain): rate_gain <= wb_dat_w[7:0];
				wb_addr_w'(reg_tilt_limit): tilt_limit <= abs_limit;
				wb_addr_w'(reg_thr_limit): thr_limit <= $signed(wb_dat_w);
				default: ;
			endcase
		end
	end

	// read data lands with ack
	always_ff @(posedge us_clk) begin
		if (req)
			wb_dat_r <= rd_word;
	end

endmodule

//--- logic/angle_controller.sv
/*
 * angle loop: stick mapping, angle feedback, gain scaling, rate limiting
 * sticks and angles are captured when a start is accepted in ang_wait
 * a start seen while running stays latched and runs once more afterwards
 * no integral term and no minimum throttle check
 */
module angle_controller #(
	parameter int frac_bits = 4
) (
	input logic us_clk,
	input logic resetn,
	input logic start,
	input flight_pkg::rx_t throttle_target,
	input flight_pkg::rx_t yaw_target,
	input flight_pkg::rx_t pitch_target,
	input flight_pkg::rx_t roll_target,
	input flight_pkg::rate_t pitch_angle,
	input flight_pkg::rate_t roll_angle,
	input flight_pkg::gain_t yaw_gain,
	input flight_pkg::gain_t tilt_gain,
	input flight_pkg::rate_t tilt_limit,
	input flight_pkg::rate_t thr_limit,
	output flight_pkg::rate_t throttle_cmd,
	output flight_pkg::rate_t yaw_rate_target,
	output flight_pkg::rate_t pitch_rate_target,
	output flight_pkg::rate_t roll_rate_target,
	output logic ang_valid,
	output logic active
);
	import flight_pkg::*;

	// headroom for stick offset plus full-scale angle
	localparam int map_w = 18;
	localparam int prod_w = map_w + 9;

	ang_state_t state, next_state;
	logic start_flag;
	logic accept;
	rx_t lat_thr, lat_yaw, lat_pitch, lat_roll;
	rate_t lat_pitch_ang, lat_roll_ang;
	rate_t m_thr;
	logic signed [map_w-1:0] m_yaw, m_pitch, m_roll;
	logic signed [prod_w-1:0] s_yaw, s_pitch, s_roll;

	// stick*4-500 in 1/16 units, rescaled to frac_bits
	function automatic logic signed [map_w-1:0] map_axis(input rx_t stick);
		logic signed [map_w-1:0] centered;
		centered = $signed({{(map_w-8){1'b0}}, stick}) * 4 - 500;
		return (centered <<< frac_bits) >>> 4;
	endfunction

	assign accept = (state == ang_wait) && start_flag;
	assign ang_valid = (state == ang_done);

	// start latch, cleared once taken in ang_wait
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			start_flag <= 1'b0;
		else
			start_flag <= start | (start_flag & (state != ang_wait));
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= ang_wait;
			active <= 1'b0;
		end else begin
			state <= next_state;
			// stays up one cycle past ang_done
			// so busy covers the rate error stage
			active <= (next_state != ang_wait) || (state == ang_done);
		end
	end

	always_comb begin
		case (state)
			ang_wait: next_state = accept ? ang_map : ang_wait;
			ang_map: next_state = ang_scale;
			ang_scale: next_state = ang_limit;
			ang_limit: next_state = ang_done;
			default: next_state = ang_wait;
		endcase
	end

	// operand capture
	always_ff @(posedge us_clk) begin
		if (accept) begin
			lat_thr <= throttle_target;
			lat_yaw <= yaw_target;
			lat_pitch <= pitch_target;
			lat_roll <= roll_target;
			lat_pitch_ang <= pitch_angle;
			lat_roll_ang <= roll_angle;
		end
	end

	always_ff @(posedge us_clk) begin
		case (state)
			ang_map: begin
				// throttle in whole units
				m_thr <= rate_t'(lat_thr) <<< frac_bits;
				m_yaw <= map_axis(lat_yaw);
				m_pitch <= map_axis(lat_pitch) - lat_pitch_ang;
				// imu roll sign is flipped
				m_roll <= map_axis(lat_roll) + lat_roll_ang;
			end
			ang_scale: begin
				s_yaw <= (m_yaw * $signed({1'b0, yaw_gain})) >>> frac_bits;
				s_pitch <= (m_pitch * $signed({1'b0, tilt_gain})) >>> frac_bits;
				s_roll <= (m_roll * $signed({1'b0, tilt_gain})) >>> frac_bits;
			end
			ang_limit: begin
				throttle_cmd <= (m_thr > thr_limit) ? thr_limit : m_thr;
				yaw_rate_target <= clamp_rate(s_yaw, -tilt_limit, tilt_limit);
				pitch_rate_target <= clamp_rate(s_pitch, -tilt_limit, tilt_limit);
				roll_rate_target <= clamp_rate(s_roll, -tilt_limit, tilt_limit);
			end
			default: ;
		endcase
	end

endmodule

//--- logic/rate_controller.sv
/*
 * proportional rate loop, two stages, fixed latency of 2 cycles
 * gyro rates are sampled on the cycle ang_valid is high
 * commands saturate to +-tilt_limit; throttle only passes through
 */
module rate_controller #(
	parameter int frac_bits = 4
) (
	input logic us_clk,
	input logic resetn,
	input logic ang_valid,
	input flight_pkg::rate_t throttle_cmd,
	input flight_pkg::rate_t yaw_rate_target,
	input flight_pkg::rate_t pitch_rate_target,
	input flight_pkg::rate_t roll_rate_target,
	input flight_pkg::rate_t gyro_yaw,
	input flight_pkg::rate_t gyro_pitch,
	input flight_pkg::rate_t gyro_roll,
	input flight_pkg::gain_t rate_gain,
	input flight_pkg::rate_t tilt_limit,
	output logic rate_valid,
	output flight_pkg::rate_t throttle_out,
	output flight_pkg::rate_t yaw_cmd,
	output flight_pkg::rate_t pitch_cmd,
	output flight_pkg::rate_t roll_cmd
);
	import flight_pkg::*;

	// one extra bit for target minus gyro
	localparam int err_w = 17;
	localparam int prod_w = err_w + 9;

	logic valid_s1;
	rate_t thr_s1;
	logic signed [err_w-1:0] err_yaw, err_pitch, err_roll;
	logic signed [prod_w-1:0] p_yaw, p_pitch, p_roll;

	// gain is unsigned, zero-extend before the signed multiply
	assign p_yaw = err_yaw * $signed({1'b0, rate_gain});
	assign p_pitch = err_pitch * $signed({1'b0, rate_gain});
	assign p_roll = err_roll * $signed({1'b0, rate_gain});

	// valid pipe
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			valid_s1 <= 1'b0;
			rate_valid <= 1'b0;
		end else begin
			valid_s1 <= ang_valid;
			rate_valid <= valid_s1;
		end
	end

	// stage one, rate error
	always_ff @(posedge us_clk) begin
		if (ang_valid) begin
			err_yaw <= yaw_rate_target - gyro_yaw;
			err_pitch <= pitch_rate_target - gyro_pitch;
			err_roll <= roll_rate_target - gyro_roll;
			thr_s1 <= throttle_cmd;
		end
	end

	// stage two, gain and saturation
	always_ff @(posedge us_clk) begin
		if (valid_s1) begin
			yaw_cmd <= clamp_rate(p_yaw >>> frac_bits, -tilt_limit, tilt_limit);
			pitch_cmd <= clamp_rate(p_pitch >>> frac_bits, -tilt_limit, tilt_limit);
			roll_cmd <= clamp_rate(p_roll >>> frac_bits, -tilt_limit, tilt_limit);
			throttle_out <= thr_s1;
		end
	end

endmodule

//--- logic/motor_mixer.sv
/*
 * quad-X mixer, one cycle after rate_valid
 * motor order front-left, front-right, rear-right, rear-left
 * each output clamps to 0..thr_limit and holds until the next done
 */
module motor_mixer (
	input logic us_clk,
	input logic resetn,
	input logic rate_valid,
	input flight_pkg::rate_t throttle_out,
	input flight_pkg::rate_t yaw_cmd,
	input flight_pkg::rate_t pitch_cmd,
	input flight_pkg::rate_t roll_cmd,
	input flight_pkg::rate_t thr_limit,
	output logic done,
	output flight_pkg::rate_t motor0,
	output flight_pkg::rate_t motor1,
	output flight_pkg::rate_t motor2,
	output flight_pkg::rate_t motor3
);
	import flight_pkg::*;

	// 18 bits so four full-scale terms cannot wrap
	logic signed [17:0] sum0, sum1, sum2, sum3;

	// front pair adds pitch
	assign sum0 = throttle_out + pitch_cmd + roll_cmd - yaw_cmd;
	assign sum1 = throttle_out + pitch_cmd - roll_cmd + yaw_cmd;
	// rear pair subtracts it
	assign sum2 = throttle_out - pitch_cmd - roll_cmd - yaw_cmd;
	assign sum3 = throttle_out - pitch_cmd + roll_cmd + yaw_cmd;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			done <= 1'b0;
		else
			done <= rate_valid;
	end

	// motors zero out of reset
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			motor0 <= '0;
			motor1 <= '0;
			motor2 <= '0;
			motor3 <= '0;
		end else if (rate_valid) begin
			motor0 <= clamp_rate(sum0, rate_t'(0), thr_limit);
			motor1 <= clamp_rate(sum1, rate_t'(0), thr_limit);
			motor2 <= clamp_rate(sum2, rate_t'(0), thr_limit);
			motor3 <= clamp_rate(sum3, rate_t'(0), thr_limit);
		end
	end

endmodule

//--- logic/flight_core.sv
/*
 * attitude path top: register block beside angle, rate and mixer stages
 * done follows an accepted start by 7 cycles; no back-pressure
 * busy spans from acceptance until the mixer result registers
 */
module flight_core #(
	parameter int frac_bits = 4,
	parameter int wb_addr_w = 3
) (
	input logic us_clk,
	input logic resetn,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [wb_addr_w-1:0] wb_adr,
	input flight_pkg::wb_data_t wb_dat_w,
	output flight_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,
	input logic start,
	input flight_pkg::rx_t throttle_target,
	input flight_pkg::rx_t yaw_target,
	input flight_pkg::rx_t pitch_target,
	input flight_pkg::rx_t roll_target,
	input flight_pkg::rate_t pitch_angle,
	input flight_pkg::rate_t roll_angle,
	input flight_pkg::rate_t gyro_yaw,
	input flight_pkg::rate_t gyro_pitch,
	input flight_pkg::rate_t gyro_roll,
	output logic busy,
	output logic done,
	output flight_pkg::rate_t motor0,
	output flight_pkg::rate_t motor1,
	output flight_pkg::rate_t motor2,
	output flight_pkg::rate_t motor3
);
	import flight_pkg::*;

	gain_t yaw_gain, tilt_gain, rate_gain;
	rate_t tilt_limit, thr_limit;
	rate_t throttle_cmd, yaw_rate_target, pitch_rate_target, roll_rate_target;
	rate_t throttle_out, yaw_cmd, pitch_cmd, roll_cmd;
	logic ang_valid, ang_active, rate_valid;

	// any stage holding work
	assign busy = ang_active | ang_valid | rate_valid;

	ctrl_regs #(.wb_addr_w(wb_addr_w)) regs_i (
		.us_clk, .resetn, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.wb_dat_r, .wb_ack, .busy,
		.yaw_gain, .tilt_gain, .rate_gain, .tilt_limit, .thr_limit
	);

	angle_controller #(.frac_bits(frac_bits)) angle_i (
		.us_clk, .resetn, .start,
		.throttle_target, .yaw_target, .pitch_target, .roll_target,
		.pitch_angle, .roll_angle,
		.yaw_gain, .tilt_gain, .tilt_limit, .thr_limit,
		.throttle_cmd, .yaw_rate_target, .pitch_rate_target, .roll_rate_target,
		.ang_valid, .active(ang_active)
	);

	rate_controller #(.frac_bits(frac_bits)) rate_i (
		.us_clk, .resetn, .ang_valid,
		.throttle_cmd, .yaw_rate_target, .pitch_rate_target, .roll_rate_target,
		.gyro_yaw, .gyro_pitch, .gyro_roll, .rate_gain, .tilt_limit,
		.rate_valid, .throttle_out, .yaw_cmd, .pitch_cmd, .roll_cmd
	);

	motor_mixer mixer_i (
		.us_clk, .resetn, .rate_valid,
		.throttle_out, .yaw_cmd, .pitch_cmd, .roll_cmd, .thr_limit,
		.done, .motor0, .motor1, .motor2, .motor3
	);

endmodule

//--- testbench/flight_core_sva.sv
/*
 * timing and handshake assertions, bound into flight_core
 * accept is the angle controller's start acceptance strobe
 */
module flight_core_sva (
	input logic us_clk,
	input logic resetn,
	input logic accept,
	input logic done,
	input logic busy,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack
);
	timeunit 1ns;
	timeprecision 100ps;

	// done is a one-cycle pulse
	done_pulse: assert property (@(posedge us_clk) disable iff (!resetn) done |=> !done)
		else $error("done high for more than one cycle");

	// fixed latency from acceptance, checked both ways
	done_latency: assert property (@(posedge us_clk) disable iff (!resetn)
		$past(accept, 7) |-> done)
		else $error("no done seven cycles after start was accepted");

	done_source: assert property (@(posedge us_clk) disable iff (!resetn)
		done |-> $past(accept, 7))
		else $error("done without an accepted start seven cycles before");

	// ack only inside a bus cycle
	ack_in_cycle: assert property (@(posedge us_clk) disable iff (!resetn)
		wb_ack |-> wb_cyc && wb_stb)
		else $error("wb_ack outside cyc and stb");

	reset_quiet: assert property (@(posedge us_clk) !resetn |-> !busy && !done && !wb_ack)
		else $error("busy, done or ack high in reset");

endmodule

//--- testbench/flight_core_tb.sv
/*
 * testbench for flight_core, stimulus and expected motors from flight_patterns.txt
 * inputs change and outputs are sampled on the falling clock edge
 * expected values in the pattern file assume frac_bits = 4
 */
module flight_core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import flight_pkg::*;

	localparam int max_rec = 64;

	logic us_clk;
	logic resetn;
	logic wb_cyc, wb_stb, wb_we;
	logic [2:0] wb_adr;
	wb_data_t wb_dat_w, wb_dat_r;
	logic wb_ack;
	logic start;
	rx_t throttle_target, yaw_target, pitch_target, roll_target;
	rate_t pitch_angle, roll_angle, gyro_yaw, gyro_pitch, gyro_roll;
	logic busy, done;
	rate_t motor0, motor1, motor2, motor3;

	// one record per pattern line
	string rec_tag [max_rec];
	string rec_name [max_rec];
	int rec_val [max_rec][13];
	int rec_count = 0;
	int vec_count = 0;
	int cycle_limit = 200;
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int dones_seen = 0;
	int dones_expected = 0;
	logic [31:0] lfsr = 32'hba9a_6580;

	flight_core #(.frac_bits(4), .wb_addr_w(3)) dut_i (
		.us_clk, .resetn, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.wb_dat_r, .wb_ack, .start,
		.throttle_target, .yaw_target, .pitch_target, .roll_target,
		.pitch_angle, .roll_angle, .gyro_yaw, .gyro_pitch, .gyro_roll,
		.busy, .done, .motor0, .motor1, .motor2, .motor3
	);

	bind flight_core flight_core_sva sva_i (
		.us_clk, .resetn, .accept(angle_i.accept), .done, .busy,
		.wb_cyc, .wb_stb, .wb_ack
	);

	initial begin
		us_clk = 1'b0;
		forever #4 us_clk = ~us_clk;
	end

	// run limit, armed from the vector count
	always @(posedge us_clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles waiting for done or ack", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	always @(negedge us_clk) begin
		if (resetn && done)
			dones_seen++;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// 0 to 3 idle cycles, one step per bit
	task automatic idle_gap();
		int gap;
		gap = 0;
		repeat (2) begin
			lfsr = lfsr_next(lfsr);
			gap = (gap << 1) | int'(lfsr[0]);
		end
		repeat (gap) @(negedge us_clk);
	endtask

	task automatic read_patterns();
		int fd;
		int code;
		string tag;
		logic [8*120-1:0] rest;
		fd = $fopen("testbench/flight_patterns.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open testbench/flight_patterns.txt");
		end else begin
			while ($fscanf(fd, "%s", tag) == 1) begin
				if (tag == "#") begin
					code = $fgets(rest, fd);
				end else if (tag == "W" || tag == "R") begin
					code = $fscanf(fd, "%h %h", rec_val[rec_count][0],
						rec_val[rec_count][1]);
					rec_tag[rec_count] = tag;
					rec_count++;
				end else begin
					code = $fscanf(fd, "%s", rec_name[rec_count]);
					for (int k = 0; k < 13; k++)
						code = $fscanf(fd, "%d", rec_val[rec_count][k]);
					rec_tag[rec_count] = tag;
					rec_count++;
					vec_count++;
				end
			end
			$fclose(fd);
		end
	endtask

	// classic cycle, held through the ack cycle
	task automatic wb_access(input logic we, input logic [2:0] adr, input wb_data_t wdat,
		output wb_data_t rdat);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdat;
		do
			@(negedge us_clk);
		while (!wb_ack);
		rdat = wb_dat_r;
		@(negedge us_clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// H lines hold start so one extra run is latched
	task automatic run_vector(input int idx);
		int hold;
		int want;
		int seen;
		logic busy_seen;
		rate_t act [4];
		hold = (rec_tag[idx] == "H") ? 3 : 1;
		want = (rec_tag[idx] == "H") ? 2 : 1;
		dones_expected += want;
		throttle_target = rx_t'(rec_val[idx][0]);
		yaw_target = rx_t'(rec_val[idx][1]);
		pitch_target = rx_t'(rec_val[idx][2]);
		roll_target = rx_t'(rec_val[idx][3]);
		pitch_angle = rate_t'(rec_val[idx][4]);
		roll_angle = rate_t'(rec_val[idx][5]);
		gyro_yaw = rate_t'(rec_val[idx][6]);
		gyro_pitch = rate_t'(rec_val[idx][7]);
		gyro_roll = rate_t'(rec_val[idx][8]);
		start = 1'b1;
		repeat (hold) @(negedge us_clk);
		start = 1'b0;
		seen = 0;
		busy_seen = 1'b0;
		while (seen < want) begin
			@(negedge us_clk);
			// busy must show up at some point while the chain runs
			if (busy)
				busy_seen = 1'b1;
			if (done) begin
				seen++;
				act = '{motor0, motor1, motor2, motor3};
				for (int m = 0; m < 4; m++) begin
					checks++;
					if (act[m] !== rate_t'(rec_val[idx][9 + m])) begin
						errors++;
						$display("Mismatch %s motor%0d: expected %0d, actual %0d",
							rec_name[idx], m, rate_t'(rec_val[idx][9 + m]), act[m]);
					end
				end
			end
		end
		checks++;
		if (!busy_seen) begin
			errors++;
			$display("%s: busy never went high while the vector ran", rec_name[idx]);
		end
	endtask

	initial begin
		wb_data_t rdat;
		resetn = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		start = 1'b0;
		throttle_target = '0;
		yaw_target = '0;
		pitch_target = '0;
		roll_target = '0;
		pitch_angle = '0;
		roll_angle = '0;
		gyro_yaw = '0;
		gyro_pitch = '0;
		gyro_roll = '0;
		read_patterns();
		cycle_limit = vec_count * 20 + 200;
		repeat (3) @(posedge us_clk);
		@(negedge us_clk);
		resetn = 1'b1;

		// outputs quiet out of reset
		checks++;
		if ({done, busy, motor0, motor1, motor2, motor3} !== '0) begin
			errors++;
			$display("Mismatch reset outputs: expected 0, actual %h",
				{done, busy, motor0, motor1, motor2, motor3});
		end

		for (int i = 0; i < rec_count; i++) begin
			if (rec_tag[i] == "W") begin
				wb_access(1'b1, 3'(rec_val[i][0]), wb_data_t'(rec_val[i][1]), rdat);
			end else if (rec_tag[i] == "R") begin
				wb_access(1'b0, 3'(rec_val[i][0]), '0, rdat);
				checks++;
				if (rdat !== wb_data_t'(rec_val[i][1])) begin
					errors++;
					$display("Mismatch read reg %0d: expected %h, actual %h",
						rec_val[i][0], wb_data_t'(rec_val[i][1]), rdat);
				end
			end else begin
				idle_gap();
				run_vector(i);
			end
		end

		// let any stray done show up
		repeat (10) @(negedge us_clk);
		checks++;
		if (dones_seen != dones_expected) begin
			errors++;
			$display("Mismatch done count: expected %0d, actual %0d",
				dones_expected, dones_seen);
		end
		$display("checks %0d, errors %0d, dones %0d", checks, errors, dones_seen);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- sim.f
logic/flight_pkg.sv
logic/ctrl_regs.sv
logic/angle_controller.sv
logic/rate_controller.sv
logic/motor_mixer.sv
logic/flight_core.sv
testbench/flight_core_sva.sv
testbench/flight_core_tb.sv

//--- Makefile
# Verilator build and run of the flight_core testbench
TOP := flight_core_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f sim.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/flight_patterns.txt
# W addr data, R addr expected (hex) | V or H name thr yaw pitch roll pitch_ang roll_ang
# gyro_yaw gyro_pitch gyro_roll motor0..motor3 (decimal, 1/16 units); H holds start 3 cycles
R 5 0000
R 1 0020
V center     125 125 125 125    0    0    0   0    0 2000 2000 2000 2000
V tilt_pitch 125 125 150 125   32    0    0  16    0 2120 2120 1880 1880
V roll_fb    125 125 125 100    0   48    0   0  -20 1916 2084 2084 1916
V yaw_mix    150 140 130 120  -24   10   30  -8    5 2321 2671 2179 2429
V sat_high   125 250 250   0 -400 -500 -300   0    0  400 4000  400  400
V sat_low    125   0   0 250  500  300  200   0 -100 3600    0 3600 3600
W 3 fce0
W 4 0960
R 3 0320
R 4 0960
V lim_thr    200 200 125 125    0    0    0   0    0 1600 2400 1600 2400
V lim_zero    50 125   0 250    0    0    0   0    0  800    0  800 2400
W 2 0020
H held       100 130 130 125    0    0   10  -5    0 1590 1790 1410 1610
